/* logic/icache_cfg_pkg.sv */
package icache_cfg_pkg;

   // Address split: tag | set | word | byte
   localparam int ADR_WIDTH       = 32;
   localparam int WORD_WIDTH      = 32;
   localparam int BLOCK_WIDTH     = 4;
   localparam int SET_WIDTH       = 4;
   localparam int NUM_SETS        = 1 << SET_WIDTH;
   localparam int NUM_WAYS        = 4;
   localparam int WORDS_PER_BLOCK = 4;
   // Word address inside one way, set and word index together
   localparam int WORD_ADR_WIDTH  = SET_WIDTH + BLOCK_WIDTH - 2;
   localparam int TAG_WIDTH       = ADR_WIDTH - SET_WIDTH - BLOCK_WIDTH;
   // One history bit for each pair of ways
   localparam int LRU_WIDTH       = NUM_WAYS * (NUM_WAYS - 1) / 2;

   typedef struct packed {
      logic                 valid;
      logic [TAG_WIDTH-1:0] tag;
   } tag_entry_t;

   typedef struct packed {
      logic [LRU_WIDTH-1:0]           lru;
      tag_entry_t [NUM_WAYS-1:0]      ways;
   } set_entry_t;

   typedef logic [NUM_WAYS-1:0][WORD_WIDTH-1:0] way_words_t;

endpackage

/* logic/icache_bus_pkg.sv */
package icache_bus_pkg;

   // Instruction cache block invalidate register
   localparam logic [15:0] ICBIR_ADDR = 16'h2002;

   // One refill word from external memory
   typedef struct packed {
      logic                                  stb;
      logic [icache_cfg_pkg::ADR_WIDTH-1:0]  adr;
      logic [icache_cfg_pkg::WORD_WIDTH-1:0] dat;
   } refill_wr_t;

   // SPR bus request, single-cycle strobe
   typedef struct packed {
      logic                                  stb;
      logic                                  we;
      logic [15:0]                           adr;
      logic [icache_cfg_pkg::WORD_WIDTH-1:0] dat;
   } spr_req_t;

   typedef enum logic [1:0] {IDLE, READ, REFILL, INVALIDATE} cache_state_e;

   typedef enum logic [2:0] {NONE, TOUCH, CLEAR_WAY, FILL, WIPE} tag_op_e;

   // Tag array command, applied to the set at the lookup address
   typedef struct packed {
      tag_op_e                              op;
      logic [icache_cfg_pkg::NUM_WAYS-1:0]  way;
      logic [icache_cfg_pkg::TAG_WIDTH-1:0] tag;
   } tag_cmd_t;

   typedef struct packed {
      logic [icache_cfg_pkg::NUM_WAYS-1:0] hit;
      logic [icache_cfg_pkg::NUM_WAYS-1:0] lru;
   } lookup_t;

endpackage

/* logic/icache_lru.sv */
`timescale 1ns/10ps

module icache_lru (
   input  logic [icache_cfg_pkg::LRU_WIDTH-1:0] current_i,
   input  logic [icache_cfg_pkg::NUM_WAYS-1:0]  access_i,
   output logic [icache_cfg_pkg::LRU_WIDTH-1:0] update_o,
   output logic [icache_cfg_pkg::NUM_WAYS-1:0] lru_o
);

   // Bit position of pair (i,j), i<j
   // A set bit means way i was used after way j
   function automatic int pair_idx(input int i, input int j);
      return i * (2 * icache_cfg_pkg::NUM_WAYS - i - 1) / 2 + (j - i - 1);
   endfunction

   // Accessed way becomes newer than every other way
   always_comb begin
      update_o = current_i;
      for (int i = 0; i < icache_cfg_pkg::NUM_WAYS; i++) begin
         for (int j = i + 1; j < icache_cfg_pkg::NUM_WAYS; j++) begin
            if (access_i[i]) begin
               update_o[pair_idx(i, j)] = 1'b1;
            end else if (access_i[j]) begin
               update_o[pair_idx(i, j)] = 1'b0;
            end
         end
      end
   end

   // LRU way is older than all the others
   // All-zero history orders way 0 oldest, way 3 newest
   always_comb begin
      for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
         lru_o[w] = 1'b1;
         for (int o = 0; o < icache_cfg_pkg::NUM_WAYS; o++) begin
            if (o < w) begin
               // Lower way must be the newer one of the pair
               lru_o[w] = lru_o[w] & current_i[pair_idx(o, w)];
            end else if (o > w) begin
               lru_o[w] = lru_o[w] & ~current_i[pair_idx(w, o)];
            end
         end
      end
   end

endmodule

/* logic/icache_tag_store.sv */
`timescale 1ns/10ps

module icache_tag_store (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [icache_cfg_pkg::ADR_WIDTH-1:0] lookup_adr_i,
   input  icache_bus_pkg::tag_cmd_t             cmd_i,
   output icache_bus_pkg::lookup_t              lookup_o
);

   // Fields of the lookup address
   logic [icache_cfg_pkg::SET_WIDTH-1:0] set_idx;
   logic [icache_cfg_pkg::TAG_WIDTH-1:0] adr_tag;

   // History and four tagged ways per set
   icache_cfg_pkg::set_entry_t sets [icache_cfg_pkg::NUM_SETS];

   // Registered read entry and compare tag
   icache_cfg_pkg::set_entry_t           rd_entry_q;
   logic [icache_cfg_pkg::TAG_WIDTH-1:0] rd_tag_q;

   // Read-modify-write path for commands
   icache_cfg_pkg::set_entry_t           cur_entry;
   icache_cfg_pkg::set_entry_t           nxt_entry;
   logic                                 set_we;
   logic [icache_cfg_pkg::LRU_WIDTH-1:0] lru_update;
   logic [icache_cfg_pkg::NUM_WAYS-1:0]  lru_way;

   assign set_idx   = lookup_adr_i[icache_cfg_pkg::BLOCK_WIDTH +: icache_cfg_pkg::SET_WIDTH];
   assign adr_tag   = lookup_adr_i[icache_cfg_pkg::ADR_WIDTH-1 -: icache_cfg_pkg::TAG_WIDTH];
   assign cur_entry = sets[set_idx];

   // History of the addressed set, way from the command
   icache_lru u_lru (
      .current_i (cur_entry.lru),
      .access_i  (cmd_i.way),
      .update_o  (lru_update),
      .lru_o     (lru_way)
   );

   always_comb begin
      nxt_entry = cur_entry;
      set_we    = 1'b1;
      case (cmd_i.op)
         icache_bus_pkg::TOUCH: begin
            nxt_entry.lru = lru_update;
         end
         icache_bus_pkg::CLEAR_WAY: begin
            // Victim goes invalid while its words are replaced
            for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
               if (cmd_i.way[w]) begin
                  nxt_entry.ways[w].valid = 1'b0;
               end
            end
         end
         icache_bus_pkg::FILL: begin
            for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
               if (cmd_i.way[w]) begin
                  nxt_entry.ways[w].valid = 1'b1;
                  nxt_entry.ways[w].tag   = cmd_i.tag;
               end
            end
            nxt_entry.lru = lru_update;
         end
         icache_bus_pkg::WIPE: begin
            nxt_entry = '0;
         end
         default: begin
            set_we = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (set_we) begin
         sets[set_idx] <= nxt_entry;
      end
   end

   // Old contents on a same-edge write
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_entry_q <= '0;
      end else begin
         rd_entry_q <= sets[set_idx];
      end
      rd_tag_q <= adr_tag;
   end

   // Compare all ways against the registered tag
   always_comb begin
      for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
         lookup_o.hit[w] = rd_entry_q.ways[w].valid && (rd_entry_q.ways[w].tag == rd_tag_q);
      end
      // Valid in READ, where the addressed set is the fetched one
      lookup_o.lru = lru_way;
   end

endmodule

/* logic/icache_way_store.sv */
`timescale 1ns/10ps

module icache_way_store (
   input  logic                                 clk,
   input  logic [icache_cfg_pkg::ADR_WIDTH-1:0] lookup_adr_i,
   input  icache_bus_pkg::refill_wr_t           refill_wr_i,
   input  logic [icache_cfg_pkg::NUM_WAYS-1:0]  way_we_i,
   output icache_cfg_pkg::way_words_t           words_o
);

   // Set and word index, byte offset dropped
   logic [icache_cfg_pkg::WORD_ADR_WIDTH-1:0] rd_idx;
   logic [icache_cfg_pkg::WORD_ADR_WIDTH-1:0] rd_idx_q;
   logic [icache_cfg_pkg::WORD_ADR_WIDTH-1:0] wr_idx;

   assign rd_idx = lookup_adr_i[icache_cfg_pkg::WORD_ADR_WIDTH+1:2];
   assign wr_idx = refill_wr_i.adr[icache_cfg_pkg::WORD_ADR_WIDTH+1:2];

   // One read address for all four ways
   always_ff @(posedge clk) begin
      rd_idx_q <= rd_idx;
   end

   for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : g_way
      logic [icache_cfg_pkg::WORD_WIDTH-1:0] mem [1 << icache_cfg_pkg::WORD_ADR_WIDTH];

      // Refill writes land only in the victim way
      always_ff @(posedge clk) begin
         if (way_we_i[w]) begin
            mem[wr_idx] <= refill_wr_i.dat;
         end
      end

      assign words_o[w] = mem[rd_idx_q];
   end

endmodule

/* logic/icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cpu_req_i,
   input  logic [icache_cfg_pkg::ADR_WIDTH-1:0]  cpu_adr_i,
   output logic                                  cpu_ack_o,
   output logic [icache_cfg_pkg::WORD_WIDTH-1:0] cpu_dat_o,
   input  icache_bus_pkg::refill_wr_t            refill_wr_i,
   output logic                                  refill_o,
   output logic                                  refill_req_o,
   input  icache_bus_pkg::spr_req_t              spr_i,
   output logic                                  spr_ack_o,
   input  icache_bus_pkg::lookup_t               lookup_i,
   input  icache_cfg_pkg::way_words_t            words_i,
   output logic [icache_cfg_pkg::ADR_WIDTH-1:0]  lookup_adr_o,
   output icache_bus_pkg::tag_cmd_t              cmd_o,
   output logic [icache_cfg_pkg::NUM_WAYS-1:0]   way_we_o
);

   icache_bus_pkg::cache_state_e state_q;
   icache_bus_pkg::cache_state_e state_d;

   logic [icache_cfg_pkg::ADR_WIDTH-1:0]       fetch_adr_q;
   logic [icache_cfg_pkg::NUM_WAYS-1:0]        victim_q;
   // Fetch waits for its word to arrive by refill
   logic                                       wait_q;
   logic [icache_cfg_pkg::WORDS_PER_BLOCK-1:0] refill_vld_q;
   logic [icache_cfg_pkg::WORDS_PER_BLOCK-1:0] refill_vld_r_q;
   logic [icache_cfg_pkg::WORDS_PER_BLOCK-1:0] refill_vld_nxt;
   logic                                       inv_pend_q;
   logic [icache_cfg_pkg::SET_WIDTH-1:0]       inv_set_q;

   logic                                       hit;
   logic                                       miss_start;
   logic                                       wipe_req;
   logic                                       refill_wr;
   logic                                       refill_first;
   logic                                       refill_last;
   logic                                       refill_ack;
   logic [icache_cfg_pkg::NUM_WAYS-1:0]        dat_sel;
   logic [icache_cfg_pkg::BLOCK_WIDTH-3:0]     fetch_word;
   logic [icache_cfg_pkg::BLOCK_WIDTH-3:0]     refill_word;

   assign hit        = |lookup_i.hit;
   assign miss_start = (state_q == icache_bus_pkg::READ) && !hit;
   assign wipe_req   = spr_i.stb && spr_i.we && (spr_i.adr == icache_bus_pkg::ICBIR_ADDR);

   assign fetch_word  = fetch_adr_q[icache_cfg_pkg::BLOCK_WIDTH-1:2];
   assign refill_word = refill_wr_i.adr[icache_cfg_pkg::BLOCK_WIDTH-1:2];
   assign refill_wr   = (state_q == icache_bus_pkg::REFILL) && refill_wr_i.stb;

   // Words seen so far, including the one on the bus
   assign refill_vld_nxt = refill_vld_q |
                           (refill_wr ? icache_cfg_pkg::WORDS_PER_BLOCK'(1) << refill_word : '0);
   assign refill_first   = refill_wr && (refill_vld_q == '0);
   assign refill_last    = refill_wr && (&refill_vld_nxt);

   // Delayed valid bit: word written and read back by the way RAM
   assign refill_ack = wait_q && refill_vld_r_q[fetch_word];

   assign cpu_ack_o    = ((state_q == icache_bus_pkg::READ) && hit) || refill_ack;
   assign refill_o     = (state_q == icache_bus_pkg::REFILL);
   assign refill_req_o = miss_start;
   assign spr_ack_o    = (state_q == icache_bus_pkg::INVALIDATE);
   assign way_we_o     = refill_wr ? victim_q : '0;

   // Word from the hitting way, or from the victim while refilling
   always_comb begin
      dat_sel   = wait_q ? victim_q : lookup_i.hit;
      cpu_dat_o = '0;
      for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
         if (dat_sel[w]) begin
            cpu_dat_o = cpu_dat_o | words_i[w];
         end
      end
   end

   // Hold the fetch address while its refill is still outstanding
   always_comb begin
      if (state_q == icache_bus_pkg::INVALIDATE) begin
         lookup_adr_o = '0;
         lookup_adr_o[icache_cfg_pkg::BLOCK_WIDTH +: icache_cfg_pkg::SET_WIDTH] = inv_set_q;
      end else if (state_q == icache_bus_pkg::IDLE && !wait_q) begin
         lookup_adr_o = cpu_adr_i;
      end else begin
         lookup_adr_o = fetch_adr_q;
      end
   end

   always_comb begin
      cmd_o.op  = icache_bus_pkg::NONE;
      cmd_o.way = victim_q;
      cmd_o.tag = fetch_adr_q[icache_cfg_pkg::ADR_WIDTH-1 -: icache_cfg_pkg::TAG_WIDTH];
      if (state_q == icache_bus_pkg::READ && hit) begin
         cmd_o.op  = icache_bus_pkg::TOUCH;
         cmd_o.way = lookup_i.hit;
      end else if (refill_last) begin
         cmd_o.op = icache_bus_pkg::FILL;
      end else if (refill_first) begin
         cmd_o.op = icache_bus_pkg::CLEAR_WAY;
      end else if (state_q == icache_bus_pkg::INVALIDATE) begin
         cmd_o.op = icache_bus_pkg::WIPE;
      end
   end

   // Invalidates wait while a refill or its acknowledge is open
   always_comb begin
      state_d = state_q;
      case (state_q)
         icache_bus_pkg::IDLE: begin
            if (!wait_q && (wipe_req || inv_pend_q)) begin
               state_d = icache_bus_pkg::INVALIDATE;
            end else if (!wait_q && cpu_req_i) begin
               state_d = icache_bus_pkg::READ;
            end
         end
         icache_bus_pkg::READ: begin
            if (!hit) begin
               state_d = icache_bus_pkg::REFILL;
            end else if (wipe_req) begin
               state_d = icache_bus_pkg::INVALIDATE;
            end else begin
               state_d = icache_bus_pkg::IDLE;
            end
         end
         icache_bus_pkg::REFILL: begin
            if (refill_last) begin
               state_d = icache_bus_pkg::IDLE;
            end
         end
         default: begin
            state_d = wipe_req ? icache_bus_pkg::INVALIDATE : icache_bus_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q        <= icache_bus_pkg::IDLE;
         wait_q         <= 1'b0;
         inv_pend_q     <= 1'b0;
         refill_vld_q   <= '0;
         refill_vld_r_q <= '0;
      end else begin
         state_q        <= state_d;
         refill_vld_r_q <= refill_vld_q;
         if (miss_start) begin
            wait_q         <= 1'b1;
            refill_vld_q   <= '0;
            refill_vld_r_q <= '0;
         end else if (refill_wr) begin
            refill_vld_q <= refill_vld_nxt;
         end
         if (refill_ack) begin
            wait_q <= 1'b0;
         end
         if (state_d == icache_bus_pkg::INVALIDATE) begin
            inv_pend_q <= 1'b0;
         end else if (wipe_req) begin
            inv_pend_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == icache_bus_pkg::IDLE && state_d == icache_bus_pkg::READ) begin
         fetch_adr_q <= cpu_adr_i;
      end
      // Victim is the LRU way of the missing set
      if (miss_start) begin
         victim_q <= lookup_i.lru;
      end
      if (wipe_req) begin
         inv_set_q <= spr_i.dat[icache_cfg_pkg::BLOCK_WIDTH +: icache_cfg_pkg::SET_WIDTH];
      end
   end

endmodule

/* logic/icache_top.sv */
`timescale 1ns/10ps

module icache_top (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  cpu_req_i,
   input  logic [icache_cfg_pkg::ADR_WIDTH-1:0]  cpu_adr_i,
   output logic                                  cpu_ack_o,
   output logic [icache_cfg_pkg::WORD_WIDTH-1:0] cpu_dat_o,
   input  icache_bus_pkg::refill_wr_t            refill_wr_i,
   output logic                                  refill_o,
   output logic                                  refill_req_o,
   input  icache_bus_pkg::spr_req_t              spr_i,
   output logic                                  spr_ack_o
);

   // Shared lookup address into both stores
   logic [icache_cfg_pkg::ADR_WIDTH-1:0] lookup_adr;
   icache_bus_pkg::tag_cmd_t             tag_cmd;
   logic [icache_cfg_pkg::NUM_WAYS-1:0]  way_we;
   // Results one cycle after the lookup address
   icache_bus_pkg::lookup_t              lookup;
   icache_cfg_pkg::way_words_t           words;

   icache_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .cpu_req_i    (cpu_req_i),
      .cpu_adr_i    (cpu_adr_i),
      .cpu_ack_o    (cpu_ack_o),
      .cpu_dat_o    (cpu_dat_o),
      .refill_wr_i  (refill_wr_i),
      .refill_o     (refill_o),
      .refill_req_o (refill_req_o),
      .spr_i        (spr_i),
      .spr_ack_o    (spr_ack_o),
      .lookup_i     (lookup),
      .words_i      (words),
      .lookup_adr_o (lookup_adr),
      .cmd_o        (tag_cmd),
      .way_we_o     (way_we)
   );

   icache_tag_store u_tag_store (
      .clk          (clk),
      .rst          (rst),
      .lookup_adr_i (lookup_adr),
      .cmd_i        (tag_cmd),
      .lookup_o     (lookup)
   );

   icache_way_store u_way_store (
      .clk          (clk),
      .lookup_adr_i (lookup_adr),
      .refill_wr_i  (refill_wr_i),
      .way_we_i     (way_we),
      .words_o      (words)
   );

endmodule

/* sim/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;

   logic                                  clk;
   logic                                  rst;
   logic                                  cpu_req;
   logic [icache_cfg_pkg::ADR_WIDTH-1:0]  cpu_adr;
   logic                                  cpu_ack;
   logic [icache_cfg_pkg::WORD_WIDTH-1:0] cpu_dat;
   icache_bus_pkg::refill_wr_t            refill_wr;
   logic                                  refill;
   logic                                  refill_req;
   icache_bus_pkg::spr_req_t              spr;
   logic                                  spr_ack;

   // Expected response of the fetch in flight
   logic                                  exp_hit;
   logic [icache_cfg_pkg::WORD_WIDTH-1:0] exp_dat;
   logic                                  fetch_active;
   logic                                  spr_active;
   // Responder still owes words of the current block
   logic                                  refill_busy;
   int                                    refill_reqs = 0;
   int                                    spr_acks = 0;

   // Separate random streams for stimulus and memory
   logic [31:0] stim_state;
   logic [31:0] resp_state;

   // Reference cache with tags, valid bits and use stamps
   // Zero stamp marks a way not filled since the last wipe
   logic                                 ref_valid [icache_cfg_pkg::NUM_SETS]
                                                   [icache_cfg_pkg::NUM_WAYS];
   logic [icache_cfg_pkg::TAG_WIDTH-1:0] ref_tag [icache_cfg_pkg::NUM_SETS]
                                                 [icache_cfg_pkg::NUM_WAYS];
   int                                   ref_stamp [icache_cfg_pkg::NUM_SETS]
                                                   [icache_cfg_pkg::NUM_WAYS];
   int                                   use_count;

   // Five tags sharing one set
   int lru_tags [11] = '{1, 2, 3, 4, 1, 5, 1, 2, 3, 4, 5};

   icache_top dut_i (
      .clk          (clk),
      .rst          (rst),
      .cpu_req_i    (cpu_req),
      .cpu_adr_i    (cpu_adr),
      .cpu_ack_o    (cpu_ack),
      .cpu_dat_o    (cpu_dat),
      .refill_wr_i  (refill_wr),
      .refill_o     (refill),
      .refill_req_o (refill_req),
      .spr_i        (spr),
      .spr_ack_o    (spr_ack)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Memory contents depend on every address bit
   function automatic logic [31:0] mem_word(input logic [31:0] adr);
      return (adr * 32'h9e37_79b1) ^ {adr[15:0], adr[31:16]} ^ 32'h1357_9bdf;
   endfunction

   function automatic void ref_wipe(input int s);
      for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
         ref_valid[s][w] = 1'b0;
         ref_tag[s][w]   = '0;
         ref_stamp[s][w] = 0;
      end
   endfunction

   // True LRU by use stamps; empty ways are always the oldest
   function automatic logic predict_hit(input logic [31:0] adr);
      int                                   s;
      int                                   hit_way;
      int                                   victim;
      logic [icache_cfg_pkg::TAG_WIDTH-1:0] tag;
      s       = int'(adr[icache_cfg_pkg::BLOCK_WIDTH +: icache_cfg_pkg::SET_WIDTH]);
      tag     = adr[icache_cfg_pkg::ADR_WIDTH-1 -: icache_cfg_pkg::TAG_WIDTH];
      hit_way = -1;
      victim  = 0;
      use_count++;
      for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
         if (ref_valid[s][w] && ref_tag[s][w] == tag) begin
            hit_way = w;
         end
         if (ref_stamp[s][w] < ref_stamp[s][victim]) begin
            victim = w;
         end
      end
      if (hit_way < 0) begin
         ref_valid[s][victim] = 1'b1;
         ref_tag[s][victim]   = tag;
         ref_stamp[s][victim] = use_count;
      end else begin
         ref_stamp[s][hit_way] = use_count;
      end
      return hit_way >= 0;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic fetch(input logic [icache_cfg_pkg::ADR_WIDTH-1:0] adr);
      int   cycles;
      int   reqs_before;
      logic ack_seen;
      // Start from an idle cache so a hit shows its fixed latency
      cycles = 0;
      @(negedge clk);
      while (refill) begin
         cycles++;
         if (cycles > 200) begin
            abort_run("timeout waiting for refill_o to fall before a fetch");
         end
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      exp_hit      = predict_hit(adr);
      exp_dat      = mem_word(adr);
      reqs_before  = refill_reqs;
      fetch_active = 1'b1;
      cpu_req      = 1'b1;
      cpu_adr      = adr;
      cycles       = 0;
      ack_seen     = 1'b0;
      while (!ack_seen) begin
         @(negedge clk);
         cycles++;
         ack_seen = cpu_ack;
         if (!ack_seen && cycles > 200) begin
            abort_run("timeout waiting for cpu_ack_o");
         end
      end
      // Sampled on the first edge, acknowledged in the cycle after it
      if (exp_hit) begin
         assert (cycles == 2)
         else abort_run($sformatf("ERR %0t cpu_ack_o latency got %0d expected 2", $time,
                                  cycles));
      end
      @(posedge clk);
      #1;
      cpu_req      = 1'b0;
      fetch_active = 1'b0;
      assert (refill_reqs - reqs_before == (exp_hit ? 0 : 1))
      else abort_run($sformatf("ERR %0t refill_req_o count got %0d expected %0d", $time,
                               refill_reqs - reqs_before, exp_hit ? 0 : 1));
   endtask

   task automatic invalidate(input logic [icache_cfg_pkg::SET_WIDTH-1:0] set_idx);
      int   cycles;
      int   acks_before;
      logic ack_seen;
      @(posedge clk);
      #1;
      acks_before = spr_acks;
      spr_active  = 1'b1;
      spr.stb     = 1'b1;
      spr.we      = 1'b1;
      spr.adr     = icache_bus_pkg::ICBIR_ADDR;
      spr.dat     = 32'(set_idx) << icache_cfg_pkg::BLOCK_WIDTH;
      // Single-cycle strobe
      @(posedge clk);
      #1;
      spr      = '0;
      cycles   = 0;
      ack_seen = 1'b0;
      while (!ack_seen) begin
         @(negedge clk);
         cycles++;
         ack_seen = spr_ack;
         if (!ack_seen && cycles > 200) begin
            abort_run("timeout waiting for spr_ack_o");
         end
      end
      // The whole block must be in before a held invalidate is answered
      assert (!refill_busy)
      else abort_run("invalidate acknowledged before the refill block was complete");
      @(posedge clk);
      #1;
      assert (spr_acks - acks_before == 1)
      else abort_run($sformatf("ERR %0t spr_ack_o count got %0d expected 1", $time,
                               spr_acks - acks_before));
      spr_active = 1'b0;
      ref_wipe(int'(set_idx));
   endtask

   // Memory side of a miss sends four words in random order and spacing
   task automatic serve_refill();
      int          order [icache_cfg_pkg::WORDS_PER_BLOCK];
      int          pick;
      int          tmp;
      int          gap;
      logic [31:0] base;
      refill_busy = 1'b1;
      base = cpu_adr;
      base[icache_cfg_pkg::BLOCK_WIDTH-1:0] = '0;
      for (int k = 0; k < icache_cfg_pkg::WORDS_PER_BLOCK; k++) begin
         order[k] = k;
      end
      for (int k = icache_cfg_pkg::WORDS_PER_BLOCK - 1; k > 0; k--) begin
         resp_state  = lcg_step(resp_state);
         pick        = int'(resp_state[23:16]) % (k + 1);
         tmp         = order[k];
         order[k]    = order[pick];
         order[pick] = tmp;
      end
      // Edge into REFILL
      @(posedge clk);
      #1;
      for (int k = 0; k < icache_cfg_pkg::WORDS_PER_BLOCK; k++) begin
         resp_state = lcg_step(resp_state);
         gap        = int'(resp_state[25:24]);
         refill_wr  = '0;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         refill_wr.stb = 1'b1;
         refill_wr.adr = base + 32'(order[k] * 4);
         refill_wr.dat = mem_word(refill_wr.adr);
         @(posedge clk);
         #1;
      end
      refill_wr   = '0;
      refill_busy = 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Mid-cycle checks of every acknowledge and request
   always @(negedge clk) begin
      if (!rst) begin
         if (cpu_ack) begin
            assert (fetch_active) else abort_run("cpu_ack_o without a pending fetch");
            assert (cpu_dat === exp_dat)
            else abort_run($sformatf("ERR %0t cpu_dat_o got %h expected %h", $time,
                                     cpu_dat, exp_dat));
         end
         if (refill_req) begin
            assert (fetch_active && !exp_hit)
            else abort_run($sformatf("ERR %0t refill_req_o got 1 expected 0", $time));
            refill_reqs++;
         end
         if (spr_ack) begin
            assert (spr_active) else abort_run("spr_ack_o without an invalidate request");
            spr_acks++;
         end
      end
   end

   initial begin
      refill_wr   = '0;
      refill_busy = 1'b0;
      resp_state  = lcg_step(32'h868d);
      forever begin
         @(negedge clk);
         if (refill_req) begin
            serve_refill();
         end
      end
   end

   initial begin
      int          cycles;
      logic [31:0] adr;
      rst          = 1'b1;
      cpu_req      = 1'b0;
      cpu_adr      = '0;
      spr          = '0;
      exp_hit      = 1'b0;
      exp_dat      = '0;
      fetch_active = 1'b0;
      spr_active   = 1'b0;
      use_count    = 0;
      stim_state   = 32'h868d;
      for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
         ref_wipe(s);
      end
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      assert (!cpu_ack && !refill && !refill_req && !spr_ack)
      else abort_run("control outputs not low after reset");

      // Tag RAM powers up unknown
      for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
         invalidate(4'(s));
      end

      // Cold miss, then hits in the same block
      fetch(32'h0000_1234);
      fetch(32'h0000_1238);
      fetch(32'h0000_1230);
      fetch(32'h0000_123c);

      // Five blocks competing for set 5
      for (int i = 0; i < 11; i++) begin
         fetch(32'h0000_0050 | (32'(lru_tags[i]) << 8) | 32'(4 * (i % 4)));
      end

      // Wiped set must miss again
      fetch(32'h0000_0394);
      fetch(32'h0000_0398);
      invalidate(4'h9);
      fetch(32'h0000_0394);

      // Invalidate held back until the refill is over
      fork
         fetch(32'h0000_07a8);
         begin
            cycles = 0;
            while (!refill) begin
               @(negedge clk);
               cycles++;
               if (cycles > 200) begin
                  abort_run("timeout waiting for refill_o to rise");
               end
            end
            invalidate(4'ha);
         end
      join
      fetch(32'h0000_07a8);

      // Random fetches with eight tags per set against four ways
      for (int n = 0; n < 400; n++) begin
         stim_state = lcg_step(stim_state);
         adr        = 32'h0000_4000 | {21'h0, stim_state[24:16], 2'b00};
         fetch(adr);
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* sources.f */
logic/icache_cfg_pkg.sv
logic/icache_bus_pkg.sv
logic/icache_lru.sv
logic/icache_tag_store.sv
logic/icache_way_store.sv
logic/icache_ctrl.sv
logic/icache_top.sv
sim/icache_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= icache_tb
RTL_TOP    ?= icache_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
VFLAGS     ?= --binary --timing --timescale 1ns/10ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
